//--- rtl/lsu_settings.svh
// LSU build settings for data width, memory size, ID width and pipeline depth
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Data and address width in bits
`define LSU_XLEN 32

// Number of data words in the built-in memory
`define LSU_MEM_WORDS 64

// Transaction ID width
`define LSU_TRANS_ID_W 3

// Width of the signed address immediate
`define LSU_IMM_W 12

// Stages between request and result
`define LSU_PIPE_DEPTH 3

`endif

//--- rtl/lsu_pkg.sv
// LSU package with the operation and exception types shared by all stages
`include "lsu_settings.svh"

package lsu_pkg;

  // ------------------------------
  // Width types
  // ------------------------------
  typedef logic [`LSU_XLEN-1:0]       xlen_t;
  typedef logic [`LSU_XLEN/8-1:0]     be_t;
  typedef logic [`LSU_TRANS_ID_W-1:0] trans_id_t;

  // ------------------------------
  // Operations and causes
  // ------------------------------
  typedef enum logic [3:0] {
    LB  = 4'd0,
    LBU = 4'd1,
    LH  = 4'd2,
    LHU = 4'd3,
    LW  = 4'd4,
    SB  = 4'd5,
    SH  = 4'd6,
    SW  = 4'd7
  } lsu_op_e;

  // RISC-V exception cause codes
  typedef enum logic [3:0] {
    EX_LD_MISALIGNED   = 4'd4,
    EX_LD_ACCESS_FAULT = 4'd5,
    EX_ST_MISALIGNED   = 4'd6,
    EX_ST_ACCESS_FAULT = 4'd7
  } ex_cause_e;

  function automatic logic op_is_store(lsu_op_e op);
    return op inside {SB, SH, SW};
  endfunction

  // Access size as log2 of the byte count: 0 byte, 1 halfword, 2 word
  function automatic logic [1:0] op_size(lsu_op_e op);
    unique case (op)
      LB, LBU, SB: return 2'd0;
      LH, LHU, SH: return 2'd1;
      default:     return 2'd2;
    endcase
  endfunction

endpackage

//--- rtl/lsu_stage_if.sv
// Pipeline item passed from one LSU stage to the next
interface lsu_stage_if
  import lsu_pkg::*;
();

  logic      valid;
  lsu_op_e   op;
  xlen_t     addr;
  be_t       be;
  // Store data already placed in its byte lanes
  xlen_t     wdata;
  xlen_t     rdata;
  trans_id_t trans_id;
  logic      ex_valid;
  ex_cause_e ex_cause;

  modport producer (
    output valid, op, addr, be, wdata, rdata, trans_id, ex_valid, ex_cause
  );

  modport consumer (
    input valid, op, addr, be, wdata, rdata, trans_id, ex_valid, ex_cause
  );

endinterface

//--- rtl/lsu_agu.sv
// LSU address stage forming the address, byte enables and exception of a request
`include "lsu_settings.svh"

module lsu_agu
  import lsu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  valid_i,
  input  lsu_op_e               op_i,
  input  xlen_t                 base_i,
  input  logic [`LSU_IMM_W-1:0] imm_i,
  input  xlen_t                 store_data_i,
  input  trans_id_t             trans_id_i,
  lsu_stage_if.producer         out_o
);

  localparam int unsigned MEM_BYTES = `LSU_MEM_WORDS * (`LSU_XLEN / 8);

  xlen_t     imm_sext;
  xlen_t     eff_addr;
  logic [1:0] byte_off;
  logic      is_store;
  be_t       be_d;
  xlen_t     wdata_d;
  logic      misaligned;
  logic      out_of_range;
  ex_cause_e cause_d;

  // ------------------------------
  // Address generation
  // ------------------------------
  assign imm_sext = {{(`LSU_XLEN - `LSU_IMM_W){imm_i[`LSU_IMM_W-1]}}, imm_i};
  assign eff_addr = base_i + imm_sext;
  assign byte_off = eff_addr[1:0];
  assign is_store = op_is_store(op_i);

  // Byte enables from access size and lane offset
  always_comb begin
    unique case (op_size(op_i))
      2'd0:    be_d = be_t'(1) << byte_off;
      2'd1:    be_d = be_t'(3) << byte_off;
      default: be_d = '1;
    endcase
  end

  // Move store data up into the addressed lanes
  assign wdata_d = is_store ? (store_data_i << {byte_off, 3'b000}) : '0;

  // ------------------------------
  // Exception check
  // ------------------------------
  always_comb begin
    unique case (op_size(op_i))
      2'd1:    misaligned = eff_addr[0];
      2'd2:    misaligned = |eff_addr[1:0];
      default: misaligned = 1'b0;
    endcase
  end

  assign out_of_range = eff_addr >= xlen_t'(MEM_BYTES);

  // Access fault outranks misalignment
  always_comb begin
    if (out_of_range) begin
      cause_d = is_store ? EX_ST_ACCESS_FAULT : EX_LD_ACCESS_FAULT;
    end else begin
      cause_d = is_store ? EX_ST_MISALIGNED : EX_LD_MISALIGNED;
    end
  end

  // ------------------------------
  // Stage register
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_o.valid    <= 1'b0;
      out_o.ex_valid <= 1'b0;
    end else begin
      out_o.valid    <= valid_i;
      out_o.ex_valid <= valid_i && (misaligned || out_of_range);
    end
  end

  always_ff @(posedge clk_i) begin
    out_o.op       <= op_i;
    out_o.addr     <= eff_addr;
    out_o.be       <= be_d;
    out_o.wdata    <= wdata_d;
    out_o.trans_id <= trans_id_i;
    out_o.ex_cause <= cause_d;
  end

  // Read data only exists after the memory stage
  assign out_o.rdata = '0;

endmodule

//--- rtl/lsu_data_mem.sv
// LSU memory stage holding the data array, with byte-enabled write and word read
`include "lsu_settings.svh"

module lsu_data_mem
  import lsu_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  lsu_stage_if.consumer in_i,
  lsu_stage_if.producer out_o
);

  localparam int unsigned IDX_W = $clog2(`LSU_MEM_WORDS);

  xlen_t            mem_q [`LSU_MEM_WORDS];
  logic [IDX_W-1:0] word_idx;
  logic             do_write;

  assign word_idx = in_i.addr[IDX_W+1:2];

  // Faulting stores never touch the array
  assign do_write = in_i.valid && op_is_store(in_i.op) && !in_i.ex_valid;

  // ------------------------------
  // Data array
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (do_write) begin
      for (int b = 0; b < `LSU_XLEN / 8; b++) begin
        if (in_i.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= in_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // ------------------------------
  // Stage register
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_o.valid    <= 1'b0;
      out_o.ex_valid <= 1'b0;
    end else begin
      out_o.valid    <= in_i.valid;
      out_o.ex_valid <= in_i.ex_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    out_o.op       <= in_i.op;
    out_o.addr     <= in_i.addr;
    out_o.be       <= in_i.be;
    out_o.wdata    <= in_i.wdata;
    out_o.trans_id <= in_i.trans_id;
    out_o.ex_cause <= in_i.ex_cause;
    // Whole word, cleared for an exception
    out_o.rdata    <= in_i.ex_valid ? '0 : mem_q[word_idx];
  end

endmodule

//--- rtl/lsu_result_align.sv
// LSU result stage aligning load data and driving the load and store result ports
`include "lsu_settings.svh"

module lsu_result_align
  import lsu_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  lsu_stage_if.consumer in_i,
  output logic          load_valid_o,
  output trans_id_t     load_trans_id_o,
  output xlen_t         load_result_o,
  output logic          load_ex_valid_o,
  output ex_cause_e     load_ex_cause_o,
  output logic          store_valid_o,
  output trans_id_t     store_trans_id_o,
  output logic          store_ex_valid_o,
  output ex_cause_e     store_ex_cause_o,
  output xlen_t         ex_tval_o
);

  xlen_t shifted;
  xlen_t load_data;
  logic  load_valid_d;
  logic  store_valid_d;

  // Steer by operation
  assign store_valid_d = in_i.valid && op_is_store(in_i.op);
  assign load_valid_d  = in_i.valid && !op_is_store(in_i.op);

  // ------------------------------
  // Load alignment
  // ------------------------------
  assign shifted = in_i.rdata >> {in_i.addr[1:0], 3'b000};

  always_comb begin
    unique case (in_i.op)
      LB:      load_data = {{(`LSU_XLEN - 8){shifted[7]}}, shifted[7:0]};
      LBU:     load_data = {{(`LSU_XLEN - 8){1'b0}}, shifted[7:0]};
      LH:      load_data = {{(`LSU_XLEN - 16){shifted[15]}}, shifted[15:0]};
      LHU:     load_data = {{(`LSU_XLEN - 16){1'b0}}, shifted[15:0]};
      default: load_data = shifted;
    endcase
  end

  // ------------------------------
  // Result registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_valid_o     <= 1'b0;
      load_trans_id_o  <= '0;
      load_result_o    <= '0;
      load_ex_valid_o  <= 1'b0;
      load_ex_cause_o  <= ex_cause_e'(0);
      store_valid_o    <= 1'b0;
      store_trans_id_o <= '0;
      store_ex_valid_o <= 1'b0;
      store_ex_cause_o <= ex_cause_e'(0);
      ex_tval_o        <= '0;
    end else begin
      load_valid_o     <= load_valid_d;
      load_ex_valid_o  <= load_valid_d && in_i.ex_valid;
      store_valid_o    <= store_valid_d;
      store_ex_valid_o <= store_valid_d && in_i.ex_valid;
      if (load_valid_d) begin
        load_trans_id_o <= in_i.trans_id;
        load_result_o   <= load_data;
        load_ex_cause_o <= in_i.ex_cause;
      end
      if (store_valid_d) begin
        store_trans_id_o <= in_i.trans_id;
        store_ex_cause_o <= in_i.ex_cause;
      end
      // Shared by whichever port fires
      if (in_i.valid) begin
        ex_tval_o <= in_i.addr;
      end
    end
  end

endmodule

//--- rtl/lsu_top.sv
// LSU top level chaining the address, memory and result stages
`include "lsu_settings.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  lsu_valid_i,
  input  lsu_op_e               op_i,
  input  xlen_t                 base_i,
  input  logic [`LSU_IMM_W-1:0] imm_i,
  input  xlen_t                 store_data_i,
  input  trans_id_t             trans_id_i,
  output logic                  load_valid_o,
  output trans_id_t             load_trans_id_o,
  output xlen_t                 load_result_o,
  output logic                  load_ex_valid_o,
  output ex_cause_e             load_ex_cause_o,
  output logic                  store_valid_o,
  output trans_id_t             store_trans_id_o,
  output logic                  store_ex_valid_o,
  output ex_cause_e             store_ex_cause_o,
  output xlen_t                 ex_tval_o
);

  // ------------------------------
  // Stage links
  // ------------------------------
  lsu_stage_if agu_to_mem ();
  lsu_stage_if mem_to_res ();

  // Stage 1
  lsu_agu u_lsu_agu (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_i      (lsu_valid_i),
    .op_i         (op_i),
    .base_i       (base_i),
    .imm_i        (imm_i),
    .store_data_i (store_data_i),
    .trans_id_i   (trans_id_i),
    .out_o        (agu_to_mem.producer)
  );

  // Stage 2
  lsu_data_mem u_lsu_data_mem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .in_i   (agu_to_mem.consumer),
    .out_o  (mem_to_res.producer)
  );

  // Stage 3
  lsu_result_align u_lsu_result_align (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .in_i             (mem_to_res.consumer),
    .load_valid_o     (load_valid_o),
    .load_trans_id_o  (load_trans_id_o),
    .load_result_o    (load_result_o),
    .load_ex_valid_o  (load_ex_valid_o),
    .load_ex_cause_o  (load_ex_cause_o),
    .store_valid_o    (store_valid_o),
    .store_trans_id_o (store_trans_id_o),
    .store_ex_valid_o (store_ex_valid_o),
    .store_ex_cause_o (store_ex_cause_o),
    .ex_tval_o        (ex_tval_o)
  );

endmodule

//--- dv/tb_clk_gen.sv
// Testbench clock and reset source with a 40 unit period and a 5 cycle reset
module tb_clk_gen #(
  parameter int unsigned HALF_PERIOD = 20,
  parameter int unsigned RST_CYCLES  = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Reset leaves on a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- dv/tb_lsu.sv
// LSU testbench with directed and random requests checked against a byte model
`include "lsu_settings.svh"

module tb_lsu
  import lsu_pkg::*;
();

  typedef struct packed {
    logic      is_store;
    xlen_t     result;
    logic      ex_valid;
    ex_cause_e cause;
    trans_id_t id;
    xlen_t     tval;
    int        due;
  } exp_t;

  logic clk;
  logic rst_n;
  logic                  req_valid;
  lsu_op_e               req_op;
  xlen_t                 req_base;
  logic [`LSU_IMM_W-1:0] req_imm;
  xlen_t                 req_data;
  trans_id_t             req_id;
  logic      load_valid;
  logic      load_ex_valid;
  logic      store_valid;
  logic      store_ex_valid;
  trans_id_t load_trans_id;
  trans_id_t store_trans_id;
  xlen_t     load_result;
  xlen_t     ex_tval;
  ex_cause_e load_ex_cause;
  ex_cause_e store_ex_cause;

  logic [7:0] model_mem [256];
  exp_t       exp_q [$];
  xlen_t      lfsr = 32'h80303a1f;
  trans_id_t  next_id = '0;
  int         cycle = 0;
  int         n_issued = 0;

  tb_clk_gen u_tb_clk_gen (.clk_o(clk), .rst_no(rst_n));

  lsu_top u_lsu_top (
    .clk_i (clk), .rst_ni (rst_n), .lsu_valid_i (req_valid), .op_i (req_op),
    .base_i (req_base), .imm_i (req_imm), .store_data_i (req_data), .trans_id_i (req_id),
    .load_valid_o (load_valid), .load_trans_id_o (load_trans_id),
    .load_result_o (load_result), .load_ex_valid_o (load_ex_valid),
    .load_ex_cause_o (load_ex_cause), .store_valid_o (store_valid),
    .store_trans_id_o (store_trans_id), .store_ex_valid_o (store_ex_valid),
    .store_ex_cause_o (store_ex_cause), .ex_tval_o (ex_tval)
  );

  always @(posedge clk) cycle <= cycle + 1;

  // ------------------------------
  // Failure reporting
  // ------------------------------
  task automatic stop_with_failure();
    $display("Testbench failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic fail_value(string sig, string exp_s, string act_s);
    $display("FAIL time=%0t signal=%s expected=%s actual=%s", $time, sig, exp_s, act_s);
    stop_with_failure();
  endtask

  task automatic fail_plain(string msg);
    $display("%s at time %0t", msg, $time);
    stop_with_failure();
  endtask

  // ------------------------------
  // Random numbers and reference
  // ------------------------------
  function automatic xlen_t rand_bits(int n);
    xlen_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Byte-level model of one request that also applies stores to the model memory
  function automatic exp_t predict(lsu_op_e op, xlen_t base, logic [`LSU_IMM_W-1:0] imm,
                                   xlen_t data, trans_id_t id);
    exp_t  e;
    xlen_t addr;
    int    n;
    logic  st;
    addr = base + {{(`LSU_XLEN - `LSU_IMM_W){imm[`LSU_IMM_W-1]}}, imm};
    case (op)
      LB, LBU, SB: n = 1;
      LH, LHU, SH: n = 2;
      default:     n = 4;
    endcase
    st = (op == SB) || (op == SH) || (op == SW);
    e = '0;
    e.is_store = st;
    e.id = id;
    e.tval = addr;
    if (addr >= 32'd256) begin
      e.ex_valid = 1'b1;
      e.cause = st ? EX_ST_ACCESS_FAULT : EX_LD_ACCESS_FAULT;
    end else if ((addr & xlen_t'(n - 1)) != '0) begin
      e.ex_valid = 1'b1;
      e.cause = st ? EX_ST_MISALIGNED : EX_LD_MISALIGNED;
    end else if (st) begin
      for (int i = 0; i < n; i++) model_mem[int'(addr) + i] = data[8*i +: 8];
    end else begin
      for (int i = 0; i < n; i++) e.result[8*i +: 8] = model_mem[int'(addr) + i];
      if (op == LB && e.result[7]) e.result[31:8] = '1;
      if (op == LH && e.result[15]) e.result[31:16] = '1;
    end
    return e;
  endfunction

  // ------------------------------
  // Compare tasks and scoreboard
  // ------------------------------
  task automatic check_load(xlen_t exp_result, logic exp_ex, ex_cause_e exp_cause,
                            trans_id_t exp_id, xlen_t exp_tval);
    if (load_trans_id !== exp_id)
      fail_value("load_trans_id_o", $sformatf("%0d", exp_id), $sformatf("%0d", load_trans_id));
    else if (load_ex_valid !== exp_ex)
      fail_value("load_ex_valid_o", $sformatf("%b", exp_ex), $sformatf("%b", load_ex_valid));
    else if (load_result !== exp_result)
      fail_value("load_result_o", $sformatf("%h", exp_result), $sformatf("%h", load_result));
    else if (exp_ex && load_ex_cause !== exp_cause)
      fail_value("load_ex_cause_o", $sformatf("%0d", exp_cause),
                 $sformatf("%0d", load_ex_cause));
    else if (exp_ex && ex_tval !== exp_tval)
      fail_value("ex_tval_o", $sformatf("%h", exp_tval), $sformatf("%h", ex_tval));
  endtask

  task automatic check_store(logic exp_ex, ex_cause_e exp_cause, trans_id_t exp_id,
                             xlen_t exp_tval);
    if (store_trans_id !== exp_id)
      fail_value("store_trans_id_o", $sformatf("%0d", exp_id), $sformatf("%0d", store_trans_id));
    else if (store_ex_valid !== exp_ex)
      fail_value("store_ex_valid_o", $sformatf("%b", exp_ex), $sformatf("%b", store_ex_valid));
    else if (exp_ex && store_ex_cause !== exp_cause)
      fail_value("store_ex_cause_o", $sformatf("%0d", exp_cause),
                 $sformatf("%0d", store_ex_cause));
    else if (exp_ex && ex_tval !== exp_tval)
      fail_value("ex_tval_o", $sformatf("%h", exp_tval), $sformatf("%h", ex_tval));
  endtask

  // Outputs are sampled half a cycle after the edge that sets them
  always @(negedge clk) begin
    exp_t item;
    if (cycle > 3 * n_issued + 50)
      fail_plain("Timeout: the run went past its cycle limit");
    else if (load_valid && store_valid)
      fail_plain("Load and store result ports fired in the same cycle");
    else if (load_valid || store_valid) begin
      if (exp_q.size() == 0 || exp_q[0].due != cycle)
        fail_plain("A result port fired when no result was due");
      else begin
        item = exp_q.pop_front();
        if (item.is_store != store_valid)
          fail_plain("A result came out on the wrong port");
        else if (item.is_store)
          check_store(item.ex_valid, item.cause, item.id, item.tval);
        else
          check_load(item.result, item.ex_valid, item.cause, item.id, item.tval);
      end
    end else if (exp_q.size() != 0 && exp_q[0].due <= cycle)
      fail_plain("An expected result did not appear on time");
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic issue(lsu_op_e op, xlen_t base, logic [`LSU_IMM_W-1:0] imm, xlen_t data);
    exp_t e;
    @(posedge clk);
    e = predict(op, base, imm, data, next_id);
    // The next edge loads the first stage and the third stage shows at the negedge after it
    e.due = cycle + `LSU_PIPE_DEPTH + 1;
    exp_q.push_back(e);
    req_valid <= 1'b1;
    req_op    <= op;
    req_base  <= base;
    req_imm   <= imm;
    req_data  <= data;
    req_id    <= next_id;
    next_id++;
    n_issued++;
  endtask

  task automatic drain();
    @(posedge clk);
    req_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  task automatic random_request();
    xlen_t                 raw;
    lsu_op_e               op;
    xlen_t                 base;
    logic [`LSU_IMM_W-1:0] imm;
    raw = rand_bits(3);
    op = lsu_op_e'(raw[3:0]);
    base = rand_bits(8);
    raw = rand_bits(3);
    if (raw[2:0] == 3'd0) begin
      raw = rand_bits(`LSU_IMM_W);
      imm = raw[`LSU_IMM_W-1:0];
    end else begin
      raw = rand_bits(4);
      imm = {{(`LSU_IMM_W - 4){1'b0}}, raw[3:0]};
    end
    raw = rand_bits(1);
    // Half of the requests are word aligned
    if (raw[0]) begin
      base[1:0] = 2'b00;
      imm[1:0]  = 2'b00;
    end
    issue(op, base, imm, rand_bits(32));
  endtask

  initial begin
    req_valid = 1'b0;
    req_op    = LB;
    req_base  = '0;
    req_imm   = '0;
    req_data  = '0;
    req_id    = '0;
    for (int i = 0; i < 256; i++) model_mem[i] = 8'h00;
    wait (rst_n === 1'b1);

    // Untouched memory reads back as zero
    issue(LW, 32'h0, 12'h000, '0);
    issue(LW, 32'h40, 12'h000, '0);
    issue(LW, 32'hfc, 12'h000, '0);
    issue(LBU, 32'h13, 12'h000, '0);
    drain();

    // Every size at every legal offset with each load right behind its store
    for (int off = 0; off < 4; off++) begin
      issue(SB, 32'h20, 12'(off), (off % 2 == 1) ? 32'habcdef70 + off : 32'h123456f0 + off);
      issue(LB, 32'h20, 12'(off), '0);
      issue(LBU, 32'h20, 12'(off), '0);
    end
    issue(LW, 32'h20, 12'h000, '0);
    for (int off = 0; off < 4; off += 2) begin
      issue(SH, 32'h30, 12'(off), (off == 0) ? 32'h55558001 : 32'haaaa7ffe);
      issue(LH, 32'h30, 12'(off), '0);
      issue(LHU, 32'h30, 12'(off), '0);
      issue(LB, 32'h30, 12'(off + 1), '0);
    end
    issue(LW, 32'h30, 12'h000, '0);
    // Negative immediate that stays in range
    issue(SW, 32'h100, 12'hf40, 32'h80f17e22);
    issue(LW, 32'h100, 12'hf40, '0);
    for (int off = 0; off < 4; off++) begin
      issue(LB, 32'h40, 12'(off), '0);
      issue(LBU, 32'h40, 12'(off), '0);
      if (off % 2 == 0) begin
        issue(LH, 32'h40, 12'(off), '0);
        issue(LHU, 32'h40, 12'(off), '0);
      end
    end
    drain();

    // Misaligned accesses leave memory alone
    issue(SH, 32'h41, 12'h000, 32'hffffffff);
    issue(SW, 32'h42, 12'h000, 32'hffffffff);
    issue(SH, 32'h3f, 12'h004, 32'hffffffff);
    issue(LH, 32'h41, 12'h000, '0);
    issue(LW, 32'h43, 12'h000, '0);
    issue(LHU, 32'h45, 12'h000, '0);
    issue(LW, 32'h40, 12'h000, '0);
    drain();

    // Out of range accesses including wrapping immediates and fault over misalignment
    issue(LW, 32'h100, 12'h000, '0);
    issue(SB, 32'h200, 12'h7ff, 32'h000000aa);
    issue(LW, 32'h4, 12'hff8, '0);
    issue(SW, 32'h10, 12'h800, 32'hdeadbeef);
    issue(LW, 32'h101, 12'h000, '0);
    issue(SH, 32'h1ff, 12'h000, 32'h00001234);
    issue(LH, 32'h101, 12'h0ff, '0);
    issue(LW, 32'h0, 12'h000, '0);
    issue(LW, 32'hfc, 12'h000, '0);
    drain();

    for (int k = 0; k < 300; k++) random_request();
    drain();

    $display("Testbench passed");
    $finish;
  end

endmodule

//--- compile.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_stage_if.sv
rtl/lsu_agu.sv
rtl/lsu_data_mem.sv
rtl/lsu_result_align.sv
rtl/lsu_top.sv
dv/tb_clk_gen.sv
dv/tb_lsu.sv

//--- Makefile
# Verilator build for the LSU testbench

VERILATOR  ?= verilator
TOP        := tb_lsu
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
SIM_BIN    := sim_$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
